/* source/fdc_pkg.sv */
package fdc_pkg;

	////////////////////////////////////////
	// Host register map

	typedef enum logic [7:0] {
		reg_sram_addr_low   = 8'h00,	// Address counter bits 7:0
		reg_sram_addr_high  = 8'h01,	// Bits 15:8
		reg_sram_addr_upper = 8'h02,	// Bits 18:16
		reg_sram_data       = 8'h03,	// SRAM data window
		reg_drive_control   = 8'h04,	// Write: drive control, read: type low
		reg_id_type_high    = 8'h05,
		reg_id_version_low  = 8'h06,
		reg_id_version_high = 8'h07,
		reg_status          = 8'h0f,	// Drive and counter status
		reg_scratch         = 8'h30,	// Bus test scratchpad
		reg_scratch_inv     = 8'h31,	// Scratchpad, inverted
		reg_fixed_55        = 8'h32,
		reg_fixed_aa        = 8'h33,
		reg_step_rate       = 8'hf0,	// Half step period in 250 us ticks, minus one
		reg_step_cmd        = 8'hff	// Bit 7 direction, bits 6:0 count
	} reg_addr_e;

	////////////////////////////////////////
	// State machines

	typedef enum logic [2:0] {
		mwc_idle,		// Waiting for a host byte
		mwc_oe_off,		// SRAM outputs off, data loaded
		mwc_write,		// WE low
		mwc_write_end,	// WE released
		mwc_inc_addr	// Bump address counter
	} mwc_state_e;

	typedef enum logic [1:0] {
		step_idle,
		step_pulse,		// Step line low
		step_gap		// Step line high between pulses
	} step_state_e;

	////////////////////////////////////////
	// Grouped signals

	// Same bit order as the register byte, density in bit 0
	typedef struct packed {
		logic       side_sel;
		logic       motor_en;
		logic [3:0] drive_sel;
		logic       in_use;
		logic       density;
	} drive_ctrl_t;

	typedef struct packed {
		logic [7:0] addr;		// Latched register address
		logic [7:0] wdata;		// Host data bus
		logic       wr_pulse;	// One cycle per write
		logic       rd_end;		// One cycle at end of read
		logic       rd_active;	// High while a read is in progress
	} host_bus_t;

	typedef struct packed {
		logic       load_low;
		logic       load_high;
		logic       load_upper;
		logic [7:0] data;
	} addr_load_t;

	// Identity, read back at 04..07
	parameter logic [15:0] mco_type    = 16'hdd55;
	parameter logic [15:0] mco_version = 16'h001c;

	parameter int sram_addr_w = 19;	// 512k x 8 part

endpackage

/* source/mcu_port.sv */
module mcu_port import fdc_pkg::*; (
	input  logic        CLK_MASTER,
	input  logic        arst_n,
	input  logic [7:0]  pmd_in,
	input  logic        pmalh,
	input  logic        pmall,
	input  logic        pmrd,
	input  logic        pmwr,
	input  logic [7:0]  sram_dq_in,
	input  logic [23:0] sram_a,		// Zero padded address counter
	input  logic        addr_empty,
	input  logic        addr_full,
	input  logic        step_busy,
	input  logic        fd_index,
	input  logic        fd_track0,
	input  logic        fd_wrprot,
	input  logic        fd_rdy,
	input  logic        fd_dens_in,
	output logic [7:0]  pmd_out,
	output drive_ctrl_t drive_ctrl,
	output logic [7:0]  step_rate,
	output logic        step_cmd,
	output logic [7:0]  step_data,
	output logic        wr_req,
	output logic [7:0]  wr_data,
	output logic        rd_inc,
	output addr_load_t  addr_load
);

	// Strobe order: pmall, pmalh, pmwr, pmrd
	logic [3:0] strb_meta, strb_sync, strb_prev;
	logic       al_rise, ah_rise, wr_rise, rd_fall;
	logic [7:0] addr_low, addr_high;
	logic       page0;
	host_bus_t  host;
	reg_addr_e  sel;
	logic [7:0] scratch;
	logic [7:0] wr_byte;		// Data of the last write
	logic [7:0] sram_dq_lat;	// Held SRAM read byte
	logic       ld_low, ld_high, ld_upper;

	////////////////////////////////////////
	// Strobe synchronizer and edges

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			strb_meta <= '0;
			strb_sync <= '0;
			strb_prev <= '0;
		end else begin
			strb_meta <= {pmrd, pmwr, pmalh, pmall};
			strb_sync <= strb_meta;
			strb_prev <= strb_sync;		// Edge detect history
		end
	end

	assign al_rise = strb_sync[0] & ~strb_prev[0];
	assign ah_rise = strb_sync[1] & ~strb_prev[1];
	assign wr_rise = strb_sync[2] & ~strb_prev[2];
	assign rd_fall = ~strb_sync[3] & strb_prev[3];	// Read ends on falling PMRD

	// Address bytes, data bus still held by the host at the edge
	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			addr_low  <= '0;
			addr_high <= '0;
		end else begin
			if (al_rise) addr_low  <= pmd_in;
			if (ah_rise) addr_high <= pmd_in;
		end
	end

	// Core registers live in page 0 only
	assign page0          = (addr_high == 8'h00);
	assign host.addr      = addr_low;
	assign host.wdata     = pmd_in;
	assign host.wr_pulse  = wr_rise & page0;
	assign host.rd_end    = rd_fall & page0;
	assign host.rd_active = strb_sync[3] & page0;
	assign sel            = reg_addr_e'(host.addr);

	////////////////////////////////////////
	// Register writes and command pulses

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			drive_ctrl <= '0;
			step_rate  <= '0;
			scratch    <= '0;
			step_cmd   <= 1'b0;
			wr_req     <= 1'b0;
			ld_low     <= 1'b0;
			ld_high    <= 1'b0;
			ld_upper   <= 1'b0;
		end else begin
			step_cmd <= 1'b0;		// Pulses last one cycle
			wr_req   <= 1'b0;
			ld_low   <= 1'b0;
			ld_high  <= 1'b0;
			ld_upper <= 1'b0;
			if (host.wr_pulse) begin
				case (sel)
					reg_sram_addr_low:   ld_low     <= 1'b1;
					reg_sram_addr_high:  ld_high    <= 1'b1;
					reg_sram_addr_upper: ld_upper   <= 1'b1;
					reg_sram_data:       wr_req     <= 1'b1;	// To write controller
					reg_drive_control:   drive_ctrl <= drive_ctrl_t'(host.wdata);
					reg_scratch:         scratch    <= host.wdata;
					reg_step_rate:       step_rate  <= host.wdata;
					reg_step_cmd:        step_cmd   <= 1'b1;
					default: ;						// Read-only or unmapped
				endcase
			end
		end
	end

	// Byte travels with whichever pulse it belongs to
	always_ff @(posedge CLK_MASTER) begin
		if (host.wr_pulse) wr_byte <= host.wdata;
	end

	assign addr_load = '{load_low: ld_low, load_high: ld_high, load_upper: ld_upper,
		data: wr_byte};
	assign wr_data   = wr_byte;
	assign step_data = wr_byte;

	////////////////////////////////////////
	// SRAM read path

	// Track the SRAM until a data read starts, then hold
	always_ff @(posedge CLK_MASTER) begin
		if (!(host.rd_active && sel == reg_sram_data)) sram_dq_lat <= sram_dq_in;
	end

	assign rd_inc = host.rd_end && (sel == reg_sram_data);	// Next byte after each read

	// Readback mux
	always_comb begin
		pmd_out = 8'h00;
		if (page0) begin
			case (sel)
				reg_sram_addr_low:   pmd_out = sram_a[7:0];
				reg_sram_addr_high:  pmd_out = sram_a[15:8];
				reg_sram_addr_upper: pmd_out = sram_a[23:16];
				reg_sram_data:       pmd_out = sram_dq_lat;
				reg_drive_control:   pmd_out = mco_type[7:0];	// Identity on read
				reg_id_type_high:    pmd_out = mco_type[15:8];
				reg_id_version_low:  pmd_out = mco_version[7:0];
				reg_id_version_high: pmd_out = mco_version[15:8];
				reg_status:          pmd_out = {fd_index, fd_track0, fd_wrprot, fd_rdy,
					fd_dens_in, step_busy, addr_empty, addr_full};
				reg_scratch:         pmd_out = scratch;
				reg_scratch_inv:     pmd_out = ~scratch;
				reg_fixed_55:        pmd_out = 8'h55;
				reg_fixed_aa:        pmd_out = 8'haa;
				default:             pmd_out = 8'h00;
			endcase
		end
	end

	// Host write and host read increments never collide at the counter
	a_no_dual_inc: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		!(wr_req && rd_inc));

endmodule

/* source/sram_addr_counter.sv */
module sram_addr_counter import fdc_pkg::*; #(
	parameter int SRAM_ADDR_W = sram_addr_w	// 17 to 24 bits
) (
	input  logic                   CLK_MASTER,
	input  logic                   arst_n,
	input  addr_load_t             addr_load,
	input  logic                   inc_write,	// From write controller
	input  logic                   inc_read,	// From host read of the data window
	output logic [SRAM_ADDR_W-1:0] sram_a,
	output logic                   empty,
	output logic                   full
);

	logic [SRAM_ADDR_W-1:0] addr_q;
	logic                   inc;
	logic                   loading;

	assign inc     = inc_write | inc_read;
	assign loading = addr_load.load_low | addr_load.load_high | addr_load.load_upper;

	////////////////////////////////////////
	// Address register

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			addr_q <= '0;
		end else if (addr_load.load_low) begin
			addr_q[7:0] <= addr_load.data;
		end else if (addr_load.load_high) begin
			addr_q[15:8] <= addr_load.data;
		end else if (addr_load.load_upper) begin
			// Only the bits the part has, 18:16 on a 512k device
			addr_q[SRAM_ADDR_W-1:16] <= addr_load.data[SRAM_ADDR_W-17:0];
		end else if (inc && !full) begin
			addr_q <= addr_q + SRAM_ADDR_W'(1);	// Stops at the top
		end
	end

	assign sram_a = addr_q;
	assign empty  = (addr_q == '0);
	assign full   = (addr_q == '1);

	// Saturation holds whichever side asked for the increment
	a_sat_hold: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		(inc && !loading && addr_q == '1) |=> (addr_q == '1));

endmodule

/* source/sram_write_ctrl.sv */
module sram_write_ctrl import fdc_pkg::*; (
	input  logic       CLK_MASTER,
	input  logic       arst_n,
	input  logic       wr_req,		// One cycle, ignored unless idle
	input  logic [7:0] wr_data,
	output logic [7:0] sram_dq_out,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic       inc_write	// One cycle, to address counter
);

	mwc_state_e state;

	////////////////////////////////////////
	// Write sequence

	// Four cycles: oe_off, write, write_end, inc_addr
	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			state     <= mwc_idle;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;	// SRAM drives the bus when idle
			inc_write <= 1'b0;
		end else begin
			inc_write <= 1'b0;
			case (state)
				mwc_idle: begin
					if (wr_req) begin
						state     <= mwc_oe_off;
						sram_oe_n <= 1'b1;	// Release the bus first
					end
				end
				mwc_oe_off: begin
					state     <= mwc_write;
					sram_we_n <= 1'b0;
				end
				mwc_write: begin
					state     <= mwc_write_end;
					sram_we_n <= 1'b1;	// Byte written on this rising edge
				end
				mwc_write_end: begin
					state     <= mwc_inc_addr;
					inc_write <= 1'b1;
				end
				mwc_inc_addr: begin
					state     <= mwc_idle;
					sram_oe_n <= 1'b0;	// Back to read mode
				end
				default: begin
					state     <= mwc_idle;
					sram_we_n <= 1'b1;
					sram_oe_n <= 1'b0;
				end
			endcase
		end
	end

	// Data register, loaded while outputs are off
	always_ff @(posedge CLK_MASTER) begin
		if (state == mwc_oe_off) sram_dq_out <= wr_data;
	end

	// No bus fight with the SRAM
	a_we_oe_excl: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		!(!sram_we_n && !sram_oe_n));

endmodule

/* source/step_controller.sv */
module step_controller import fdc_pkg::*; #(
	parameter int TICK_DIV = 25000		// Clocks per 250 us tick
) (
	input  logic       CLK_MASTER,
	input  logic       arst_n,
	input  logic [7:0] step_rate,	// Half period in ticks, minus one
	input  logic       step_cmd,	// One cycle
	input  logic [7:0] step_data,	// Bit 7 outward, 6:0 count
	input  logic       fd_track0,
	output logic       fd_step,		// Active low
	output logic       fd_dir,		// 1 = outward
	output logic       busy
);

	localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	step_state_e       state;
	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic [7:0]        rate_cnt;
	logic              half_done;	// End of a pulse or a gap
	logic [6:0]        steps_left;
	logic              start;
	logic              stop_now;

	// Zero count and commands while busy are dropped
	assign start = step_cmd && (state == step_idle) && (step_data[6:0] != 7'd0);

	////////////////////////////////////////
	// Time base

	assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			tick_cnt <= '0;
		end else if (start || tick) begin
			tick_cnt <= '0;		// Realign so the first pulse is full length
		end else begin
			tick_cnt <= tick_cnt + TICK_W'(1);
		end
	end

	// Rate divider, step_rate + 1 ticks per half period
	assign half_done = tick && (rate_cnt >= step_rate);

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			rate_cnt <= '0;
		end else if (start) begin
			rate_cnt <= '0;
		end else if (tick) begin
			rate_cnt <= half_done ? 8'd0 : rate_cnt + 8'd1;
		end
	end

	////////////////////////////////////////
	// Pulse FSM

	// Done, or heading in and already at track 0
	assign stop_now = (steps_left == 7'd0) || (!fd_dir && fd_track0);

	always_ff @(posedge CLK_MASTER or negedge arst_n) begin
		if (!arst_n) begin
			state      <= step_idle;
			fd_step    <= 1'b1;
			fd_dir     <= 1'b0;
			steps_left <= '0;
		end else begin
			case (state)
				step_idle: begin
					if (start) begin
						fd_dir     <= step_data[7];	// Held for the whole command
						steps_left <= step_data[6:0];
						fd_step    <= 1'b0;
						state      <= step_pulse;
					end
				end
				step_pulse: begin
					if (half_done) begin
						fd_step    <= 1'b1;
						steps_left <= steps_left - 7'd1;	// One step issued
						state      <= step_gap;
					end
				end
				step_gap: begin
					if (half_done) begin
						if (stop_now) begin
							state <= step_idle;
						end else begin
							fd_step <= 1'b0;
							state   <= step_pulse;
						end
					end
				end
				default: state <= step_idle;
			endcase
		end
	end

	assign busy = (state != step_idle);

	// Step line only moves inside a command
	a_step_in_busy: assert property (@(posedge CLK_MASTER) disable iff (!arst_n)
		!fd_step |-> busy);

endmodule

/* source/fdc_top.sv */
module fdc_top import fdc_pkg::*; #(
	parameter int SRAM_ADDR_W = sram_addr_w,	// 17 to 24 bits
	parameter int TICK_DIV    = 25000		// 250 us at 100 MHz
) (
	input  logic                   CLK_MASTER,
	input  logic                   arst_n,
	// Host port
	input  logic [7:0]             pmd_in,
	input  logic                   pmalh,
	input  logic                   pmall,
	input  logic                   pmrd,
	input  logic                   pmwr,
	output logic [7:0]             pmd_out,
	// SRAM
	output logic [SRAM_ADDR_W-1:0] sram_a,
	output logic [7:0]             sram_dq_out,
	output logic                   sram_we_n,
	output logic                   sram_oe_n,
	output logic                   sram_ce_n,
	input  logic [7:0]             sram_dq_in,
	// Drive outputs, active low at the pins
	output logic                   fd_dens,
	output logic                   fd_inuse,
	output logic [3:0]             fd_drvsel,
	output logic                   fd_moten,
	output logic                   fd_sidesel,
	output logic                   fd_step,
	output logic                   fd_dir,
	// Drive status
	input  logic                   fd_track0,
	input  logic                   fd_index,
	input  logic                   fd_wrprot,
	input  logic                   fd_rdy,
	input  logic                   fd_dens_in
);

	drive_ctrl_t drive_ctrl;
	addr_load_t  addr_load;
	logic [7:0]  step_rate;
	logic        step_cmd;
	logic [7:0]  step_data;
	logic        step_busy;
	logic        wr_req;
	logic [7:0]  wr_data;
	logic        rd_inc;
	logic        inc_write;
	logic        addr_empty;
	logic        addr_full;
	logic [23:0] addr_rb;	// Address padded to three readback bytes

	assign addr_rb   = 24'(sram_a);
	assign sram_ce_n = 1'b0;	// Chip always selected

	assign fd_dens    = ~drive_ctrl.density;
	assign fd_inuse   = ~drive_ctrl.in_use;
	assign fd_drvsel  = ~drive_ctrl.drive_sel;
	assign fd_moten   = ~drive_ctrl.motor_en;
	assign fd_sidesel = ~drive_ctrl.side_sel;

	mcu_port u_mcu_port (
		.CLK_MASTER (CLK_MASTER),
		.arst_n     (arst_n),
		.pmd_in     (pmd_in),
		.pmalh      (pmalh),
		.pmall      (pmall),
		.pmrd       (pmrd),
		.pmwr       (pmwr),
		.sram_dq_in (sram_dq_in),
		.sram_a     (addr_rb),
		.addr_empty (addr_empty),
		.addr_full  (addr_full),
		.step_busy  (step_busy),
		.fd_index   (fd_index),
		.fd_track0  (fd_track0),
		.fd_wrprot  (fd_wrprot),
		.fd_rdy     (fd_rdy),
		.fd_dens_in (fd_dens_in),
		.pmd_out    (pmd_out),
		.drive_ctrl (drive_ctrl),
		.step_rate  (step_rate),
		.step_cmd   (step_cmd),
		.step_data  (step_data),
		.wr_req     (wr_req),
		.wr_data    (wr_data),
		.rd_inc     (rd_inc),
		.addr_load  (addr_load)
	);

	sram_addr_counter #(.SRAM_ADDR_W(SRAM_ADDR_W)) u_addr_counter (
		.CLK_MASTER (CLK_MASTER),
		.arst_n     (arst_n),
		.addr_load  (addr_load),
		.inc_write  (inc_write),
		.inc_read   (rd_inc),
		.sram_a     (sram_a),
		.empty      (addr_empty),
		.full       (addr_full)
	);

	sram_write_ctrl u_write_ctrl (
		.CLK_MASTER  (CLK_MASTER),
		.arst_n      (arst_n),
		.wr_req      (wr_req),
		.wr_data     (wr_data),
		.sram_dq_out (sram_dq_out),
		.sram_we_n   (sram_we_n),
		.sram_oe_n   (sram_oe_n),
		.inc_write   (inc_write)
	);

	step_controller #(.TICK_DIV(TICK_DIV)) u_step_ctrl (
		.CLK_MASTER (CLK_MASTER),
		.arst_n     (arst_n),
		.step_rate  (step_rate),
		.step_cmd   (step_cmd),
		.step_data  (step_data),
		.fd_track0  (fd_track0),
		.fd_step    (fd_step),
		.fd_dir     (fd_dir),
		.busy       (step_busy)
	);

endmodule

/* bench/sram_model.sv */
module sram_model #(
	parameter int ADDR_W = 19
) (
	input  logic [ADDR_W-1:0] a,
	input  logic [7:0]        din,	// From controller data register
	output logic [7:0]        dout,	// To controller read path
	input  logic              we_n,
	input  logic              oe_n,
	input  logic              ce_n
);

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////
	// Storage, open to the testbench

	logic [7:0] mem [0:(1 << ADDR_W) - 1];

	// Byte taken at the end of the WE pulse, like the real part
	always @(posedge we_n) begin
		if (ce_n === 1'b0 && !$isunknown(a)) begin
			mem[a] <= din;
		end
	end

	// Bus idles high when the outputs are off
	assign dout = (!ce_n && !oe_n) ? mem[a] : 8'hff;

endmodule

/* bench/tb_fdc.sv */
module tb_fdc import fdc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int OP_CYC   = 16;	// Address latch and one strobe, 8 cycles each
	localparam int POLL_MAX = 40;	// Status reads per stepping command
	// Host operations per test: drive, identity, burst, read, stepping
	localparam int OPS_TOTAL   = 2 + 9 + 22 + 31 + (4 + 2 * POLL_MAX);
	localparam int WATCHDOG_NS = 2 * (10 + OPS_TOTAL * OP_CYC) * 20;

	logic                   CLK_MASTER, arst_n;
	logic [7:0]             pmd_in, pmd_out;
	logic                   pmalh, pmall, pmrd, pmwr;
	logic [sram_addr_w-1:0] sram_a;
	logic [7:0]             sram_dq_out, sram_dq_in;
	logic                   sram_we_n, sram_oe_n, sram_ce_n;
	logic                   fd_dens, fd_inuse, fd_moten, fd_sidesel, fd_step, fd_dir;
	logic [3:0]             fd_drvsel;
	logic                   fd_track0, fd_index, fd_wrprot, fd_rdy, fd_dens_in;

	int                     mismatches, failures;
	int                     step_falls = 0;	// Running count of fd_step falling edges
	logic [31:0]            lfsr;
	logic [7:0]             burst [16];		// Bytes of the SRAM burst
	logic [sram_addr_w-1:0] burst_start;

	fdc_top #(.SRAM_ADDR_W(sram_addr_w), .TICK_DIV(8)) dut0 (.*);

	sram_model #(.ADDR_W(sram_addr_w)) sram0 (
		.a    (sram_a),
		.din  (sram_dq_out),
		.dout (sram_dq_in),
		.we_n (sram_we_n),
		.oe_n (sram_oe_n),
		.ce_n (sram_ce_n)
	);

	always #10 CLK_MASTER = ~CLK_MASTER;	// 20 ns period

	always @(negedge fd_step) step_falls = step_falls + 1;

	////////////////////////////////////////
	// Helpers

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		repeat (n) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Pins in register bit order, density at bit 0
	function automatic logic [7:0] drive_pins();
		return {fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens};
	endfunction

	// index, track0, wrprot, rdy, dens_in, busy, empty, full
	function automatic logic [7:0] status_byte(logic busy, logic empty, logic full);
		return {fd_index, fd_track0, fd_wrprot, fd_rdy, fd_dens_in, busy, empty, full};
	endfunction

	task automatic cycles(int n);
		repeat (n) @(posedge CLK_MASTER);
		#2;	// Drive point
	endtask

	task automatic check(string what, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			mismatches++;
			$display("mismatch at %0d ns: %s, expected %h, got %h", $time, what, exp, act);
		end
	endtask

	task automatic latch_addr(logic [7:0] addr);
		pmd_in = addr;
		pmall  = 1'b1;
		cycles(4);
		pmall  = 1'b0;
		cycles(4);
	endtask

	task automatic host_write(logic [7:0] addr, logic [7:0] data);
		latch_addr(addr);
		pmd_in = data;
		pmwr   = 1'b1;
		cycles(4);
		pmwr   = 1'b0;
		cycles(4);
	endtask

	task automatic host_read(logic [7:0] addr, output logic [7:0] data);
		latch_addr(addr);
		pmrd = 1'b1;
		cycles(4);
		data = pmd_out;		// Settled since the address latch
		pmrd = 1'b0;
		cycles(4);
	endtask

	task automatic expect_read(logic [7:0] addr, logic [7:0] exp, string what);
		logic [7:0] v;
		host_read(addr, v);
		check(what, 32'(exp), 32'(v));
	endtask

	task automatic load_addr(logic [sram_addr_w-1:0] a);
		host_write(reg_sram_addr_low, a[7:0]);
		host_write(reg_sram_addr_high, a[15:8]);
		host_write(reg_sram_addr_upper, 8'(a >> 16));	// Low bits of the third byte
	endtask

	task automatic read_addr(output logic [sram_addr_w-1:0] a);
		logic [7:0] lo, hi, up;
		logic [23:0] full;
		host_read(reg_sram_addr_low, lo);
		host_read(reg_sram_addr_high, hi);
		host_read(reg_sram_addr_upper, up);
		full = {up, hi, lo};
		a = full[sram_addr_w-1:0];
	endtask

	// Poll busy in the status byte until it clears
	task automatic wait_step_done(output logic busy_seen);
		logic [7:0] st;
		int n;
		n = 0;
		host_read(reg_status, st);
		busy_seen = st[2];
		while (st[2] && n < POLL_MAX) begin
			host_read(reg_status, st);
			n++;
		end
		assert (!st[2]) else begin
			failures++;
			$display("Stepping command still busy after %0d status reads", POLL_MAX);
		end
	endtask

	////////////////////////////////////////
	// Directed tests

	task automatic test_drive_control();
		logic [7:0] d, nd;
		check("drive pins after reset", 32'h0ff, 32'(drive_pins()));
		check("fd_step after reset", 32'd1, 32'(fd_step));
		check("we_n/oe_n/ce_n after reset", 32'd4, 32'({sram_we_n, sram_oe_n, sram_ce_n}));
		d  = 8'(rand_bits(8));
		nd = ~d;
		host_write(reg_drive_control, d);
		check("drive pins", 32'(nd), 32'(drive_pins()));
	endtask

	task automatic test_identity();
		logic [7:0] s, ns;
		expect_read(reg_drive_control, mco_type[7:0], "type low");
		expect_read(reg_id_type_high, mco_type[15:8], "type high");
		expect_read(reg_id_version_low, mco_version[7:0], "version low");
		expect_read(reg_id_version_high, mco_version[15:8], "version high");
		s  = 8'(rand_bits(8));
		ns = ~s;
		host_write(reg_scratch, s);
		expect_read(reg_scratch, s, "scratch");
		expect_read(reg_scratch_inv, ns, "scratch inverted");
		expect_read(reg_fixed_55, 8'h55, "fixed 55");
		expect_read(reg_fixed_aa, 8'haa, "fixed aa");
	endtask

	task automatic test_sram_burst();
		logic [sram_addr_w-1:0] a;
		burst_start = sram_addr_w'(rand_bits(18));	// Room left for 16 bytes
		load_addr(burst_start);
		for (int i = 0; i < 16; i++) begin
			burst[i] = 8'(rand_bits(8));
			host_write(reg_sram_data, burst[i]);
		end
		for (int i = 0; i < 16; i++) begin
			check("SRAM array byte", 32'(burst[i]),
				32'(sram0.mem[burst_start + sram_addr_w'(i)]));
		end
		read_addr(a);
		check("address after burst", 32'(burst_start + sram_addr_w'(16)), 32'(a));
	endtask

	task automatic test_sram_read();
		logic [7:0] v;
		logic [sram_addr_w-1:0] a, top;
		top = '1;
		load_addr(burst_start);
		for (int i = 0; i < 16; i++) begin
			host_read(reg_sram_data, v);
			check("SRAM read byte", 32'(burst[i]), 32'(v));
		end
		load_addr('0);
		expect_read(reg_status, status_byte(1'b0, 1'b1, 1'b0), "status at address zero");
		load_addr(top);
		expect_read(reg_status, status_byte(1'b0, 1'b0, 1'b1), "status at top address");
		host_write(reg_sram_data, 8'(rand_bits(8)));	// Counter must saturate
		read_addr(a);
		check("address held at top", 32'(top), 32'(a));
	endtask

	task automatic test_stepping();
		logic busy_seen;
		int f0;
		host_write(reg_step_rate, 8'd1);	// 4 ticks per step
		f0 = step_falls;
		host_write(reg_step_cmd, 8'h85);	// Outward, 5 steps
		check("fd_dir outward", 32'd1, 32'(fd_dir));
		wait_step_done(busy_seen);
		check("busy during outward command", 32'd1, 32'(busy_seen));
		check("outward step pulses", 32'd5, 32'(step_falls - f0));
		fd_track0 = 1'b1;
		f0 = step_falls;
		host_write(reg_step_cmd, 8'h14);	// Inward, 20 steps, already at track 0
		check("fd_dir inward", 32'd0, 32'(fd_dir));
		wait_step_done(busy_seen);
		assert (step_falls - f0 < 20) else begin
			failures++;
			$display("Inward command at track 0 issued all 20 step pulses");
		end
		fd_track0 = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		CLK_MASTER = 1'b0;
		arst_n     = 1'b0;
		pmd_in     = 8'h00;
		{pmalh, pmall, pmrd, pmwr} = 4'b0000;
		// Alternating levels across the status byte
		{fd_track0, fd_index, fd_wrprot, fd_rdy, fd_dens_in} = 5'b01101;
		lfsr       = 32'hd9a5bc67;
		mismatches = 0;
		failures   = 0;
		cycles(10);
		arst_n = 1'b1;
		cycles(2);
		test_drive_control();
		test_identity();
		test_sram_burst();
		test_sram_read();
		test_stepping();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
source/fdc_pkg.sv
source/mcu_port.sv
source/sram_addr_counter.sv
source/sram_write_ctrl.sv
source/step_controller.sv
source/fdc_top.sv
bench/sram_model.sv
bench/tb_fdc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FDC core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fdc -f filelist.f \
	--Mdir obj_dir -o tb_fdc_sim

out=$(./obj_dir/tb_fdc_sim)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
	exit 0
else
	exit 1
fi
